/* common/harness_pkg.sv */
// Harness package with bus widths, region map codes, the address view and the boot ROM table
package harness_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 64;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  localparam int unsigned WordOffsetBits = 3;
  localparam int unsigned IdxWidth       = 16;

  // ----------------------------------------
  // Region map
  // ----------------------------------------
  // 256 MB regions picked by the top address nibble
  localparam int unsigned RegionWidth = 4;
  localparam int unsigned OffsetWidth = AddrWidth - RegionWidth;

  localparam logic [RegionWidth-1:0] RegionRom  = 4'h1;
  localparam logic [RegionWidth-1:0] RegionDram = 4'h8;

  // Target codes carried from decoder to memory port
  localparam int unsigned TgtWidth = 2;

  localparam logic [TgtWidth-1:0] TgtRom  = 2'd0;
  localparam logic [TgtWidth-1:0] TgtDram = 2'd1;
  localparam logic [TgtWidth-1:0] TgtErr  = 2'd2;

  // Address word, seen raw or split into region and offset
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      logic [RegionWidth-1:0] region;
      logic [OffsetWidth-1:0] offset;
    } fields;
  } addr_u;

  // ----------------------------------------
  // Boot ROM
  // ----------------------------------------
  localparam int unsigned RomWords = 8;

  // Upper half is a tag plus the index, lower half its inverse
  function automatic logic [DataWidth-1:0] rom_word(input logic [IdxWidth-1:0] idx);
    logic [DataWidth/2-1:0] upper;
    upper = {16'hB007, idx};
    return {upper, ~upper};
  endfunction

endpackage

/* source/rst_dbg_ctrl.sv */
// System reset synchronizer and hold-off gate for the core debug request
module rst_dbg_ctrl #(
  parameter int unsigned DbgHoldCycles = 500
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_en_i,
  input  logic debug_req_i,
  output logic sys_rst_no,
  output logic debug_req_o
);

  localparam int unsigned CntWidth = (DbgHoldCycles > 0) ? $clog2(DbgHoldCycles + 1) : 1;

  logic                rst_comb_n;
  logic [1:0]          sync_q;
  logic [CntWidth-1:0] hold_cnt_q;

  // Power-on reset or a reset request from the debugger
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // ----------------------------------------
  // Reset synchronizer
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

  // ----------------------------------------
  // Debug request hold-off
  // ----------------------------------------
  // Gives boot code time to run before a halt request can land
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_cnt_q <= CntWidth'(DbgHoldCycles);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (hold_cnt_q == '0) & debug_en_i & debug_req_i;

endmodule

/* bus/bus_decode.sv */
// Request decoder mapping an address to its target and word index
module bus_decode #(
  parameter int unsigned SramWords = 256
) (
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  input  logic                              we_i,
  output logic [harness_pkg::TgtWidth-1:0]  tgt_o,
  output logic [harness_pkg::IdxWidth-1:0]  idx_o
);

  localparam int unsigned WordIdxWidth =
    harness_pkg::OffsetWidth - harness_pkg::WordOffsetBits;

  harness_pkg::addr_u      addr;
  logic                    misaligned;
  logic [WordIdxWidth-1:0] word_idx;

  assign addr.raw = addr_i;

  // Byte lane bits must be zero for a word access
  assign misaligned = addr.raw[harness_pkg::WordOffsetBits-1:0] != '0;

  assign word_idx = addr.fields.offset[harness_pkg::OffsetWidth-1:harness_pkg::WordOffsetBits];
  assign idx_o    = word_idx[harness_pkg::IdxWidth-1:0];

  // ----------------------------------------
  // Target select
  // ----------------------------------------
  always_comb begin
    tgt_o = harness_pkg::TgtErr;
    if (misaligned) begin
      tgt_o = harness_pkg::TgtErr;
    end else if (addr.fields.region == harness_pkg::RegionRom) begin
      // ROM is read only
      if (!we_i && (word_idx < harness_pkg::RomWords)) begin
        tgt_o = harness_pkg::TgtRom;
      end
    end else if (addr.fields.region == harness_pkg::RegionDram) begin
      if (word_idx < SramWords) begin
        tgt_o = harness_pkg::TgtDram;
      end
    end
  end

endmodule

/* bus/req_fifo.sv */
// In-order request queue between the decoder and the memory port, with grant generation
module req_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              push_i,
  input  logic [harness_pkg::TgtWidth-1:0]  tgt_i,
  input  logic [harness_pkg::IdxWidth-1:0]  idx_i,
  input  logic                              we_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  input  logic                              pop_i,
  output logic                              gnt_o,
  output logic                              valid_o,
  output logic [harness_pkg::TgtWidth-1:0]  tgt_o,
  output logic [harness_pkg::IdxWidth-1:0]  idx_o,
  output logic                              we_o,
  output logic [harness_pkg::StrbWidth-1:0] be_o,
  output logic [harness_pkg::DataWidth-1:0] wdata_o
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  logic [harness_pkg::TgtWidth-1:0]  tgt_mem   [FifoDepth];
  logic [harness_pkg::IdxWidth-1:0]  idx_mem   [FifoDepth];
  logic                              we_mem    [FifoDepth];
  logic [harness_pkg::StrbWidth-1:0] be_mem    [FifoDepth];
  logic [harness_pkg::DataWidth-1:0] wdata_mem [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign valid_o = count_q != '0;
  // A pop frees a slot in the same cycle, so a full queue still grants
  assign gnt_o   = rst_ni & ((count_q < FifoDepth) | (pop_i & valid_o));
  assign do_push = push_i & gnt_o;
  assign do_pop  = pop_i & valid_o;

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      tgt_mem[wr_ptr_q]   <= tgt_i;
      idx_mem[wr_ptr_q]   <= idx_i;
      we_mem[wr_ptr_q]    <= we_i;
      be_mem[wr_ptr_q]    <= be_i;
      wdata_mem[wr_ptr_q] <= wdata_i;
    end
  end

  assign tgt_o   = tgt_mem[rd_ptr_q];
  assign idx_o   = idx_mem[rd_ptr_q];
  assign we_o    = we_mem[rd_ptr_q];
  assign be_o    = be_mem[rd_ptr_q];
  assign wdata_o = wdata_mem[rd_ptr_q];

endmodule

/* mem/mem_port.sv */
// Memory port serving queued requests from boot ROM, SRAM or the error responder
module mem_port #(
  parameter int unsigned SramWords = 256
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_i,
  input  logic [harness_pkg::TgtWidth-1:0]  tgt_i,
  input  logic [harness_pkg::IdxWidth-1:0]  idx_i,
  input  logic                              we_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  input  logic                              rready_i,
  output logic                              pop_o,
  output logic                              rvalid_o,
  output logic [harness_pkg::DataWidth-1:0] rdata_o,
  output logic                              err_o
);

  localparam int unsigned SramIdxWidth = (SramWords > 1) ? $clog2(SramWords) : 1;

  logic [harness_pkg::DataWidth-1:0] sram_q [SramWords];
  logic [SramIdxWidth-1:0]           sram_idx;
  logic                              sram_wr;

  logic [harness_pkg::DataWidth-1:0] rdata_d;
  logic                              err_d;

  logic                              rvalid_q;
  logic [harness_pkg::DataWidth-1:0] rdata_q;
  logic                              err_q;

  // Decoder already bounds the index below SramWords
  assign sram_idx = idx_i[SramIdxWidth-1:0];

  // Take the head when the response slot is empty or draining
  assign pop_o   = valid_i & (~rvalid_q | rready_i);
  assign sram_wr = pop_o & we_i & (tgt_i == harness_pkg::TgtDram);

  // ----------------------------------------
  // SRAM
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (sram_wr) begin
      for (int b = 0; b < harness_pkg::StrbWidth; b++) begin
        if (be_i[b]) begin
          sram_q[sram_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Response select
  // ----------------------------------------
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (tgt_i)
      harness_pkg::TgtRom: begin
        rdata_d = harness_pkg::rom_word(idx_i);
      end
      harness_pkg::TgtDram: begin
        // Writes answer with zero data
        if (!we_i) begin
          rdata_d = sram_q[sram_idx];
        end
      end
      default: begin
        err_d = 1'b1;
      end
    endcase
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (pop_o) begin
      rvalid_q <= 1'b1;
    end else if (rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

endmodule

/* source/harness_top.sv */
// Harness top level joining reset control, request decoder, request queue and memory port
module harness_top #(
  parameter int unsigned FifoDepth     = 4,
  parameter int unsigned SramWords     = 256,
  parameter int unsigned DbgHoldCycles = 500
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              ndmreset_i,
  input  logic                              debug_en_i,
  input  logic                              debug_req_i,
  output logic                              debug_req_o,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [harness_pkg::AddrWidth-1:0] addr_i,
  input  logic [harness_pkg::StrbWidth-1:0] be_i,
  input  logic [harness_pkg::DataWidth-1:0] wdata_i,
  output logic                              gnt_o,
  output logic                              rvalid_o,
  output logic [harness_pkg::DataWidth-1:0] rdata_o,
  output logic                              err_o,
  input  logic                              rready_i
);

  logic                             sys_rst_n;
  logic                             push;
  logic [harness_pkg::TgtWidth-1:0] dec_tgt;
  logic [harness_pkg::IdxWidth-1:0] dec_idx;

  logic                              q_valid;
  logic                              q_pop;
  logic [harness_pkg::TgtWidth-1:0]  q_tgt;
  logic [harness_pkg::IdxWidth-1:0]  q_idx;
  logic                              q_we;
  logic [harness_pkg::StrbWidth-1:0] q_be;
  logic [harness_pkg::DataWidth-1:0] q_wdata;

  // ----------------------------------------
  // Reset and debug control
  // ----------------------------------------
  rst_dbg_ctrl #(
    .DbgHoldCycles ( DbgHoldCycles )
  ) i_rst_dbg_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_i ( debug_req_i ),
    .sys_rst_no  ( sys_rst_n   ),
    .debug_req_o ( debug_req_o )
  );

  // ----------------------------------------
  // Request path
  // ----------------------------------------
  // Accept on strobe and grant
  assign push = req_i & gnt_o;

  bus_decode #(
    .SramWords ( SramWords )
  ) i_bus_decode (
    .addr_i ( addr_i  ),
    .we_i   ( we_i    ),
    .tgt_o  ( dec_tgt ),
    .idx_o  ( dec_idx )
  );

  req_fifo #(
    .FifoDepth ( FifoDepth )
  ) i_req_fifo (
    .clk_i   ( clk_i     ),
    .rst_ni  ( sys_rst_n ),
    .push_i  ( push      ),
    .tgt_i   ( dec_tgt   ),
    .idx_i   ( dec_idx   ),
    .we_i    ( we_i      ),
    .be_i    ( be_i      ),
    .wdata_i ( wdata_i   ),
    .pop_i   ( q_pop     ),
    .gnt_o   ( gnt_o     ),
    .valid_o ( q_valid   ),
    .tgt_o   ( q_tgt     ),
    .idx_o   ( q_idx     ),
    .we_o    ( q_we      ),
    .be_o    ( q_be      ),
    .wdata_o ( q_wdata   )
  );

  mem_port #(
    .SramWords ( SramWords )
  ) i_mem_port (
    .clk_i    ( clk_i     ),
    .rst_ni   ( sys_rst_n ),
    .valid_i  ( q_valid   ),
    .tgt_i    ( q_tgt     ),
    .idx_i    ( q_idx     ),
    .we_i     ( q_we      ),
    .be_i     ( q_be      ),
    .wdata_i  ( q_wdata   ),
    .rready_i ( rready_i  ),
    .pop_o    ( q_pop     ),
    .rvalid_o ( rvalid_o  ),
    .rdata_o  ( rdata_o   ),
    .err_o    ( err_o     )
  );

endmodule

/* verif/tb_harness_ref.svh */
// Reference model of the harness memory side with shadow SRAM and expected responses
`ifndef TB_HARNESS_REF_SVH
`define TB_HARNESS_REF_SVH

// Shadow copy of the DUT SRAM, updated when a write is accepted
logic [DataWidth-1:0] shadow_sram [SramWords];

// Expected responses in request order, error flag above the data
logic [DataWidth:0]   exp_q [$];

// Boot ROM rule: tag and index on top, inverse below
function automatic logic [DataWidth-1:0] expected_rom(input int unsigned idx);
  logic [31:0] hi;
  hi = {16'hb007, idx[15:0]};
  return {hi, ~hi};
endfunction

// Expected response of one request, with the SRAM write applied to the shadow
function automatic logic [DataWidth:0] model_access(input logic                 we,
                                                   input logic [AddrWidth-1:0] addr,
                                                   input logic [StrbWidth-1:0] be,
                                                   input logic [DataWidth-1:0] wdata);
  logic [3:0]           region;
  int unsigned          idx;
  logic [DataWidth-1:0] merged;
  int                   b;
  region = addr[31:28];
  // 256 MB regions, 8-byte words
  idx    = addr[27:3];
  if (addr[2:0] != 3'b000) begin
    return {1'b1, {DataWidth{1'b0}}};
  end
  if (region == harness_pkg::RegionRom && !we && idx < harness_pkg::RomWords) begin
    return {1'b0, expected_rom(idx)};
  end
  if (region == harness_pkg::RegionDram && idx < SramWords) begin
    if (!we) begin
      return {1'b0, shadow_sram[idx]};
    end
    merged = shadow_sram[idx];
    for (b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    shadow_sram[idx] = merged;
    return {1'b0, {DataWidth{1'b0}}};
  end
  return {1'b1, {DataWidth{1'b0}}};
endfunction

`endif

/* verif/tb_harness.sv */
// Testbench for the harness memory port, system reset and debug request hold-off
module tb_harness;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned FifoDepth     = 4;
  localparam int unsigned SramWords     = 256;
  localparam int unsigned DbgHoldCycles = 500;
  localparam int unsigned AddrWidth     = harness_pkg::AddrWidth;
  localparam int unsigned DataWidth     = harness_pkg::DataWidth;
  localparam int unsigned StrbWidth     = harness_pkg::StrbWidth;
  localparam int unsigned NumWords      = 8;
  // Requests over all tests, rounded up
  localparam int unsigned NumRequests   = 64;
  localparam int unsigned TimeoutCycles = NumRequests * (FifoDepth + 4) + DbgHoldCycles + 200;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 ndmreset_i;
  logic                 debug_en_i;
  logic                 debug_req_i;
  logic                 debug_req_o;
  logic                 req_i;
  logic                 we_i;
  logic [AddrWidth-1:0] addr_i;
  logic [StrbWidth-1:0] be_i;
  logic [DataWidth-1:0] wdata_i;
  logic                 gnt_o;
  logic                 rvalid_o;
  logic [DataWidth-1:0] rdata_o;
  logic                 err_o;
  logic                 rready_i;

  string                test_name;
  int unsigned          error_count;
  int unsigned          check_count;
  int unsigned          errors_at_start;
  int unsigned          tests_run;
  int unsigned          tests_failed;
  logic                 ready_random;
  logic [DataWidth:0]   expected_resp;
  int unsigned          word_idx [NumWords];

  `include "tb_harness_ref.svh"

  harness_top #(
    .FifoDepth     ( FifoDepth     ),
    .SramWords     ( SramWords     ),
    .DbgHoldCycles ( DbgHoldCycles )
  ) i_dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .gnt_o       ( gnt_o       ),
    .rvalid_o    ( rvalid_o    ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .rready_i    ( rready_i    )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic report_mismatch(input string what, input logic [DataWidth-1:0] expected,
                                 input logic [DataWidth-1:0] actual);
    $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
    error_count++;
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("Test %s ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s had %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  function automatic logic [AddrWidth-1:0] sram_addr(input int unsigned idx);
    return 32'h8000_0000 | (idx << 3);
  endfunction

  // One request, held until granted, with its expected response queued
  task automatic send(input logic we, input logic [AddrWidth-1:0] addr,
                      input logic [StrbWidth-1:0] be, input logic [DataWidth-1:0] wdata);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    be_i    = be;
    wdata_i = wdata;
    @(negedge clk_i);
    while (!gnt_o) begin
      @(negedge clk_i);
    end
    exp_q.push_back(model_access(we, addr, be, wdata));
    step();
    req_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    #2;
  endtask

  // Random response back-pressure
  always @(posedge clk_i) begin
    if (ready_random) begin
      #2;
      rready_i = 1'($urandom % 2);
    end
  end

  // ----------------------------------------
  // Response compare
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (rvalid_o && rready_i) begin
      if (exp_q.size() == 0) begin
        $display("ERROR %s: response arrived with no request outstanding", test_name);
        error_count++;
      end else begin
        expected_resp = exp_q.pop_front();
        check_count++;
        if (rdata_o !== expected_resp[DataWidth-1:0]) begin
          report_mismatch("rdata", expected_resp[DataWidth-1:0], rdata_o);
        end
        if (err_o !== expected_resp[DataWidth]) begin
          report_mismatch("err", expected_resp[DataWidth], err_o);
        end
      end
    end
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic debug_holdoff();
    int unsigned early;
    begin_test("debug_holdoff");
    early = 0;
    for (int n = 0; n < DbgHoldCycles; n++) begin
      @(negedge clk_i);
      if (debug_req_o !== 1'b0) begin
        early++;
      end
    end
    check_count++;
    if (early != 0) begin
      $display("ERROR %s: debug request passed %0d cycles early", test_name, early);
      error_count++;
    end
    @(negedge clk_i);
    check_count++;
    if (debug_req_o !== 1'b1) begin
      report_mismatch("after hold-off", 1, debug_req_o);
    end
    step();
    debug_req_i = 1'b0;
    @(negedge clk_i);
    check_count++;
    if (debug_req_o !== 1'b0) begin
      report_mismatch("request low", 0, debug_req_o);
    end
    step();
    debug_req_i = 1'b1;
    debug_en_i  = 1'b0;
    @(negedge clk_i);
    check_count++;
    if (debug_req_o !== 1'b0) begin
      report_mismatch("debug disabled", 0, debug_req_o);
    end
    step();
    debug_en_i = 1'b1;
    end_test();
  endtask

  task automatic rom_reads();
    begin_test("rom_reads");
    // One extra read past the table
    for (int i = 0; i <= harness_pkg::RomWords; i++) begin
      send(1'b0, 32'h1000_0000 + 8 * i, '1, '0);
    end
    drain();
    end_test();
  endtask

  task automatic sram_merge();
    logic [StrbWidth-1:0] be;
    begin_test("sram_merge");
    ready_random = 1'b1;
    for (int i = 0; i < NumWords; i++) begin
      word_idx[i] = $urandom % SramWords;
      send(1'b1, sram_addr(word_idx[i]), '1, {$urandom, $urandom});
    end
    for (int i = 0; i < NumWords; i++) begin
      be = StrbWidth'($urandom);
      send(1'b1, sram_addr(word_idx[i]), be, {$urandom, $urandom});
    end
    for (int i = 0; i < NumWords; i++) begin
      send(1'b0, sram_addr(word_idx[i]), '1, '0);
    end
    drain();
    ready_random = 1'b0;
    step();
    rready_i = 1'b1;
    end_test();
  endtask

  task automatic error_responses();
    begin_test("error_responses");
    send(1'b0, 32'h4000_0000, '1, '0);
    send(1'b1, 32'h1000_0008, '1, 64'h1234);
    send(1'b0, 32'h8000_0004, '1, '0);
    send(1'b0, sram_addr(SramWords), '1, '0);
    drain();
    end_test();
  endtask

  task automatic backpressure();
    int unsigned accepted;
    begin_test("backpressure");
    rready_i = 1'b0;
    accepted = 0;
    req_i    = 1'b1;
    we_i     = 1'b0;
    be_i     = '1;
    wdata_i  = '0;
    addr_i   = sram_addr(word_idx[0]);
    for (int cyc = 0; cyc < FifoDepth + 5; cyc++) begin
      @(negedge clk_i);
      if (gnt_o) begin
        exp_q.push_back(model_access(we_i, addr_i, be_i, wdata_i));
        accepted++;
      end
      step();
      addr_i = sram_addr(word_idx[accepted % NumWords]);
    end
    req_i = 1'b0;
    check_count++;
    if (accepted != FifoDepth + 1) begin
      report_mismatch("accepted", FifoDepth + 1, accepted);
    end
    rready_i = 1'b1;
    drain();
    end_test();
  endtask

  task automatic ndmreset_pulse();
    begin_test("ndmreset");
    send(1'b1, sram_addr(200), '1, {$urandom, $urandom});
    send(1'b1, sram_addr(201), '1, {$urandom, $urandom});
    drain();
    rready_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      send(1'b0, sram_addr(200 + i % 2), '1, '0);
    end
    ndmreset_i = 1'b1;
    // Pending responses are lost with the reset
    exp_q.delete();
    repeat (2) begin
      @(negedge clk_i);
      check_count++;
      if (gnt_o !== 1'b0 || rvalid_o !== 1'b0) begin
        $display("ERROR %s: grant or response active during reset", test_name);
        error_count++;
      end
      if (debug_req_o !== 1'b1) begin
        report_mismatch("debug_req during reset", 1, debug_req_o);
      end
      step();
    end
    ndmreset_i = 1'b0;
    repeat (2) begin
      @(negedge clk_i);
      check_count++;
      if (gnt_o !== 1'b0) begin
        report_mismatch("gnt before release", 0, gnt_o);
      end
    end
    @(negedge clk_i);
    check_count++;
    if (gnt_o !== 1'b1) begin
      report_mismatch("gnt after release", 1, gnt_o);
    end
    step();
    rready_i = 1'b1;
    send(1'b0, sram_addr(200), '1, '0);
    send(1'b0, sram_addr(201), '1, '0);
    drain();
    end_test();
  endtask

  // ----------------------------------------
  // Sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'h8c66));
    error_count  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    ready_random = 1'b0;
    rst_ni       = 1'b0;
    ndmreset_i   = 1'b0;
    debug_en_i   = 1'b1;
    debug_req_i  = 1'b1;
    req_i        = 1'b0;
    we_i         = 1'b0;
    addr_i       = '0;
    be_i         = '0;
    wdata_i      = '0;
    rready_i     = 1'b1;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    debug_holdoff();
    rom_reads();
    sram_merge();
    error_responses();
    backpressure();
    ndmreset_pulse();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* compile.f */
+incdir+verif
common/harness_pkg.sv
source/rst_dbg_ctrl.sv
bus/bus_decode.sv
bus/req_fifo.sv
mem/mem_port.sv
source/harness_top.sv
verif/tb_harness.sv

/* Bender.yml */
package:
  name: harness_mem

sources:
  # Shared package first
  - files:
      - common/harness_pkg.sv

  - files:
      - source/rst_dbg_ctrl.sv
      - bus/bus_decode.sv
      - bus/req_fifo.sv
      - mem/mem_port.sv
      - source/harness_top.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_harness.sv
